// File: rtl/riscv_pkg.sv
// shared types, access encodings and csr map of the data unit

package riscv_pkg;

  ////////////////////////////////////////////////////////////
  // basic widths
  ////////////////////////////////////////////////////////////

  typedef logic [31:0] xlen_t;      // data or address word
  typedef logic [3:0]  be_t;        // one enable per byte lane
  typedef logic [11:0] csr_addr_t;

  // access size, same encoding as the ex stage data_type
  typedef enum logic [1:0] {
    MEM_BYTE = 2'b00,
    MEM_HALF = 2'b01,
    MEM_WORD = 2'b10
  } mem_type_e;

  ////////////////////////////////////////////////////////////
  // records carried by the lsu fifos
  ////////////////////////////////////////////////////////////

  // one issued operation, kept until its response is matched
  typedef struct packed {
    logic      we;          // store
    mem_type_e mem_type;
    logic      sign_ext;    // loads only
    logic [1:0] offset;     // byte offset inside the word
    xlen_t     addr;        // full byte address, used for error capture
    logic      rejected;    // misaligned, never went on the bus
  } lsu_pend_t;

  // one finished operation as seen by the writeback side
  typedef struct packed {
    xlen_t rdata;           // zero for stores and errors
    logic  err;
  } lsu_res_t;

  ////////////////////////////////////////////////////////////
  // csr map, custom perf counter space
  ////////////////////////////////////////////////////////////

  localparam csr_addr_t CSR_LOAD_CNT  = 12'h785;
  localparam csr_addr_t CSR_STORE_CNT = 12'h786;
  localparam csr_addr_t CSR_ERR_CNT   = 12'h787;
  localparam csr_addr_t CSR_ERR_ADDR  = 12'h788;

  // operations in flight, pending plus finished
  localparam int LSU_DEPTH_DEFAULT = 2;

endpackage

// File: rtl/riscv_lsu_fifo.sv
// small register-array fifo with a typed payload and a fill count

`timescale 1ns/1ps

module riscv_lsu_fifo #(
  parameter int  DEPTH  = riscv_pkg::LSU_DEPTH_DEFAULT,
  parameter type item_t = logic
) (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       push_i,
  input  item_t      push_data_i,
  input  logic       pop_i,
  output item_t      pop_data_o,
  output logic       empty_o,
  output logic [1:0] count_o      // entries held for the admit check and busy
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  item_t             mem_q [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;    // tail
  logic [PTR_W-1:0]  rd_ptr_q;    // head
  logic [1:0]        count_q;

  // pointer step with wrap for non power of two depths
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    ptr_next = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // storage array
  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= push_data_i;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (pop_i)  rd_ptr_q <= ptr_next(rd_ptr_q);
      count_q <= count_q + 2'(push_i) - 2'(pop_i);   // push and pop may coincide
    end
  end

  assign pop_data_o = mem_q[rd_ptr_q];   // head is visible without a pop
  assign empty_o    = (count_q == 2'd0);
  assign count_o    = count_q;

endmodule

// File: rtl/riscv_lsu_req.sv
// request side of the lsu: admit check, alignment, byte enables and bus request

`timescale 1ns/1ps

module riscv_lsu_req #(
  parameter int DEPTH = riscv_pkg::LSU_DEPTH_DEFAULT
) (
  // operation stream from ex
  input  logic                 op_valid_i,
  output logic                 op_ready_o,
  input  logic                 op_we_i,
  input  riscv_pkg::mem_type_e op_type_i,
  input  logic                 op_sign_ext_i,
  input  riscv_pkg::xlen_t     op_addr_i,
  input  riscv_pkg::xlen_t     op_wdata_i,

  // fill state of both fifos
  input  logic [1:0]           pend_count_i,
  input  logic [1:0]           res_count_i,

  // data bus request channel
  output logic                 data_req_o,
  input  logic                 data_gnt_i,
  output logic                 data_we_o,
  output riscv_pkg::be_t       data_be_o,
  output riscv_pkg::xlen_t     data_addr_o,
  output riscv_pkg::xlen_t     data_wdata_o,

  // pending record push
  output logic                 pend_push_o,
  output riscv_pkg::lsu_pend_t pend_data_o,

  // perf events and status
  output logic                 load_issue_o,
  output logic                 store_issue_o,
  output logic                 busy_o
);

  import riscv_pkg::*;

  logic [1:0] offset;
  logic [2:0] in_flight;     // pending plus finished, widened for the sum
  logic       admit;
  logic       misaligned;
  logic       granted;
  logic       reject_accept;

  assign offset    = op_addr_i[1:0];
  assign in_flight = {1'b0, pend_count_i} + {1'b0, res_count_i};
  assign admit     = (in_flight < 3'(DEPTH));   // also keeps result fifo from filling

  ////////////////////////////////////////////////////////////
  // alignment and lane selection
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (op_type_i)
      MEM_BYTE: begin
        misaligned = 1'b0;
        data_be_o  = be_t'(4'b0001 << offset);
      end
      MEM_HALF: begin
        misaligned = (offset == 2'd3);              // would cross into next word
        data_be_o  = be_t'(4'b0011 << offset);
      end
      default: begin                                // word, spare code as word
        misaligned = (offset != 2'd0);
        data_be_o  = 4'b1111;
      end
    endcase
  end

  // rotate store data onto its byte lanes
  always_comb begin
    case (offset)
      2'd0:    data_wdata_o = op_wdata_i;
      2'd1:    data_wdata_o = {op_wdata_i[23:0], op_wdata_i[31:24]};
      2'd2:    data_wdata_o = {op_wdata_i[15:0], op_wdata_i[31:16]};
      default: data_wdata_o = {op_wdata_i[7:0],  op_wdata_i[31:8]};
    endcase
  end

  ////////////////////////////////////////////////////////////
  // handshakes
  ////////////////////////////////////////////////////////////

  // upstream holds the op until ready, so req stays stable until gnt
  assign data_req_o  = op_valid_i & admit & ~misaligned;
  assign data_we_o   = op_we_i;
  assign data_addr_o = {op_addr_i[31:2], 2'b00};   // bus is word addressed

  assign granted = data_req_o & data_gnt_i;

  // a rejected op waits for an empty pending fifo
  // its pop at the head then never meets an rvalid of a later request
  assign reject_accept = op_valid_i & admit & misaligned & (pend_count_i == 2'd0);

  assign op_ready_o  = granted | reject_accept;     // accept coincides with gnt
  assign pend_push_o = op_ready_o;

  always_comb begin
    pend_data_o.we       = op_we_i;
    pend_data_o.mem_type = op_type_i;
    pend_data_o.sign_ext = op_sign_ext_i;
    pend_data_o.offset   = offset;
    pend_data_o.addr     = op_addr_i;
    pend_data_o.rejected = misaligned;
  end

  assign load_issue_o  = granted & ~op_we_i;   // perf counters count on grant
  assign store_issue_o = granted &  op_we_i;

  assign busy_o = (pend_count_i != 2'd0) | (res_count_i != 2'd0) | op_valid_i;

endmodule

// File: rtl/riscv_lsu_resp.sv
// response side of the lsu: matches rvalid to records, aligns load data, flags errors

`timescale 1ns/1ps

module riscv_lsu_resp (
  input  logic                 clk_i,
  input  logic                 rst_i,

  // head of the pending fifo
  input  logic                 pend_empty_i,
  input  riscv_pkg::lsu_pend_t pend_data_i,
  output logic                 pend_pop_o,

  // data bus response channel
  input  logic                 data_rvalid_i,
  input  riscv_pkg::xlen_t     data_rdata_i,
  input  logic                 data_err_i,

  // result fifo push
  output logic                 res_push_o,
  output riscv_pkg::lsu_res_t  res_data_o,

  // error event towards the csr block
  output logic                 err_o,
  output riscv_pkg::xlen_t     err_addr_o
);

  import riscv_pkg::*;

  xlen_t shifted;      // addressed byte moved down to lane 0
  xlen_t load_data;
  logic  res_err;
  logic  err_q;
  xlen_t err_addr_q;

  // rvalid answers the head in order; a rejected head retires at once
  assign pend_pop_o = ~pend_empty_i & (pend_data_i.rejected | data_rvalid_i);
  assign res_err    = pend_data_i.rejected | (data_rvalid_i & data_err_i);

  assign shifted = data_rdata_i >> {pend_data_i.offset, 3'b000};

  always_comb begin
    case (pend_data_i.mem_type)
      MEM_BYTE: load_data = pend_data_i.sign_ext ? {{24{shifted[7]}}, shifted[7:0]}
                                                 : {24'h0, shifted[7:0]};
      MEM_HALF: load_data = pend_data_i.sign_ext ? {{16{shifted[15]}}, shifted[15:0]}
                                                 : {16'h0, shifted[15:0]};
      default:  load_data = shifted;
    endcase
  end

  // the result fifo register gives res_valid one cycle after rvalid
  assign res_push_o = pend_pop_o;

  always_comb begin
    res_data_o.rdata = (res_err | pend_data_i.we) ? '0 : load_data;
    res_data_o.err   = res_err;
  end

  ////////////////////////////////////////////////////////////
  // error event, one cycle pulse with the faulting address
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) err_q <= 1'b0;
    else       err_q <= pend_pop_o & res_err;
  end

  always_ff @(posedge clk_i) begin
    if (pend_pop_o & res_err) err_addr_q <= pend_data_i.addr;   // byte address
  end

  assign err_o      = err_q;
  assign err_addr_o = err_addr_q;

endmodule

// File: rtl/riscv_cs_registers.sv
// memory access perf counters and error address register behind a csr port

`timescale 1ns/1ps

module riscv_cs_registers (
  input  logic                 clk_i,
  input  logic                 rst_i,

  // events from the lsu
  input  logic                 load_issue_i,
  input  logic                 store_issue_i,
  input  logic                 err_i,
  input  riscv_pkg::xlen_t     err_addr_i,

  // csr port, read in the same cycle, write on the clock
  input  logic                 csr_req_i,
  input  logic                 csr_we_i,
  input  riscv_pkg::csr_addr_t csr_addr_i,
  input  riscv_pkg::xlen_t     csr_wdata_i,
  output riscv_pkg::xlen_t     csr_rdata_o
);

  import riscv_pkg::*;

  xlen_t load_cnt_q;
  xlen_t store_cnt_q;
  xlen_t err_cnt_q;
  xlen_t err_addr_q;    // most recent faulting address
  logic  csr_wr;

  assign csr_wr = csr_req_i & csr_we_i;

  ////////////////////////////////////////////////////////////
  // counters, csr write wins over an increment
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      load_cnt_q  <= '0;
      store_cnt_q <= '0;
      err_cnt_q   <= '0;
      err_addr_q  <= '0;
    end else begin
      if (csr_wr && csr_addr_i == CSR_LOAD_CNT) load_cnt_q <= csr_wdata_i;
      else if (load_issue_i)                    load_cnt_q <= load_cnt_q + 1'b1;   // wraps

      if (csr_wr && csr_addr_i == CSR_STORE_CNT) store_cnt_q <= csr_wdata_i;
      else if (store_issue_i)                    store_cnt_q <= store_cnt_q + 1'b1;

      if (csr_wr && csr_addr_i == CSR_ERR_CNT) err_cnt_q <= csr_wdata_i;
      else if (err_i)                          err_cnt_q <= err_cnt_q + 1'b1;

      if (csr_wr && csr_addr_i == CSR_ERR_ADDR) err_addr_q <= csr_wdata_i;
      else if (err_i)                           err_addr_q <= err_addr_i;
    end
  end

  // read mux, unmapped or idle reads return zero
  always_comb begin
    csr_rdata_o = '0;
    if (csr_req_i) begin
      case (csr_addr_i)
        CSR_LOAD_CNT:  csr_rdata_o = load_cnt_q;
        CSR_STORE_CNT: csr_rdata_o = store_cnt_q;
        CSR_ERR_CNT:   csr_rdata_o = err_cnt_q;
        CSR_ERR_ADDR:  csr_rdata_o = err_addr_q;
        default:       csr_rdata_o = '0;
      endcase
    end
  end

endmodule

// File: rtl/riscv_data_unit.sv
// data side top level: lsu request and response, two fifos and the csr block

`timescale 1ns/1ps

module riscv_data_unit #(
  parameter int DEPTH = riscv_pkg::LSU_DEPTH_DEFAULT
) (
  input  logic                 clk_i,
  input  logic                 rst_i,

  // operation stream
  input  logic                 op_valid_i,
  output logic                 op_ready_o,
  input  logic                 op_we_i,
  input  riscv_pkg::mem_type_e op_type_i,
  input  logic                 op_sign_ext_i,
  input  riscv_pkg::xlen_t     op_addr_i,
  input  riscv_pkg::xlen_t     op_wdata_i,

  // result stream
  output logic                 res_valid_o,
  input  logic                 res_ready_i,
  output riscv_pkg::xlen_t     res_rdata_o,
  output logic                 res_err_o,

  // data memory interface
  output logic                 data_req_o,
  input  logic                 data_gnt_i,
  input  logic                 data_rvalid_i,
  output logic                 data_we_o,
  output riscv_pkg::be_t       data_be_o,
  output riscv_pkg::xlen_t     data_addr_o,
  output riscv_pkg::xlen_t     data_wdata_o,
  input  riscv_pkg::xlen_t     data_rdata_i,
  input  logic                 data_err_i,

  // csr port, debug style
  input  logic                 csr_req_i,
  input  logic                 csr_we_i,
  input  riscv_pkg::csr_addr_t csr_addr_i,
  input  riscv_pkg::xlen_t     csr_wdata_i,
  output riscv_pkg::xlen_t     csr_rdata_o,

  output logic                 busy_o
);

  import riscv_pkg::*;

  // pending fifo
  logic      pend_push, pend_pop, pend_empty;
  lsu_pend_t pend_data, pend_head;
  logic [1:0] pend_count;

  // result fifo
  logic      res_push, res_pop, res_empty;
  lsu_res_t  res_data, res_head;
  logic [1:0] res_count;

  // events for the counters
  logic      load_issue, store_issue, lsu_err;
  xlen_t     lsu_err_addr;

  ////////////////////////////////////////////////////////////
  // load store unit
  ////////////////////////////////////////////////////////////

  riscv_lsu_req #(.DEPTH(DEPTH)) lsu_req_i (
    .op_valid_i    (op_valid_i),
    .op_ready_o    (op_ready_o),
    .op_we_i       (op_we_i),
    .op_type_i     (op_type_i),
    .op_sign_ext_i (op_sign_ext_i),
    .op_addr_i     (op_addr_i),
    .op_wdata_i    (op_wdata_i),
    .pend_count_i  (pend_count),
    .res_count_i   (res_count),
    .data_req_o    (data_req_o),
    .data_gnt_i    (data_gnt_i),
    .data_we_o     (data_we_o),
    .data_be_o     (data_be_o),
    .data_addr_o   (data_addr_o),
    .data_wdata_o  (data_wdata_o),
    .pend_push_o   (pend_push),
    .pend_data_o   (pend_data),
    .load_issue_o  (load_issue),
    .store_issue_o (store_issue),
    .busy_o        (busy_o)
  );

  riscv_lsu_fifo #(.DEPTH(DEPTH), .item_t(lsu_pend_t)) pending_fifo_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .push_i      (pend_push),    // on grant or rejected accept
    .push_data_i (pend_data),
    .pop_i       (pend_pop),
    .pop_data_o  (pend_head),
    .empty_o     (pend_empty),
    .count_o     (pend_count)
  );

  riscv_lsu_resp lsu_resp_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .pend_empty_i  (pend_empty),
    .pend_data_i   (pend_head),
    .pend_pop_o    (pend_pop),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .data_err_i    (data_err_i),
    .res_push_o    (res_push),
    .res_data_o    (res_data),
    .err_o         (lsu_err),
    .err_addr_o    (lsu_err_addr)
  );

  riscv_lsu_fifo #(.DEPTH(DEPTH), .item_t(lsu_res_t)) result_fifo_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .push_i      (res_push),     // never full, bounded by the admit check
    .push_data_i (res_data),
    .pop_i       (res_pop),
    .pop_data_o  (res_head),
    .empty_o     (res_empty),
    .count_o     (res_count)
  );

  // result stream straight off the fifo head
  assign res_valid_o = ~res_empty;
  assign res_pop     = res_valid_o & res_ready_i;
  assign res_rdata_o = res_head.rdata;
  assign res_err_o   = res_head.err;

  ////////////////////////////////////////////////////////////
  // control and status registers
  ////////////////////////////////////////////////////////////

  riscv_cs_registers cs_registers_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .load_issue_i  (load_issue),
    .store_issue_i (store_issue),
    .err_i         (lsu_err),
    .err_addr_i    (lsu_err_addr),
    .csr_req_i     (csr_req_i),
    .csr_we_i      (csr_we_i),
    .csr_addr_i    (csr_addr_i),
    .csr_wdata_i   (csr_wdata_i),
    .csr_rdata_o   (csr_rdata_o)
  );

endmodule

// File: testbench/riscv_data_unit_asserts.sv
// protocol assertions for the data bus and result stream of the data unit

`timescale 1ns/1ps

module riscv_data_unit_asserts (
  input logic             clk_i,
  input logic             rst_i,
  input logic             data_req_o,
  input logic             data_gnt_i,
  input logic             data_we_o,
  input riscv_pkg::be_t   data_be_o,
  input riscv_pkg::xlen_t data_addr_o,
  input riscv_pkg::xlen_t data_wdata_o,
  input logic             data_rvalid_i,
  input logic             res_valid_o,
  input logic             res_ready_i,
  input riscv_pkg::xlen_t res_rdata_o,
  input logic             res_err_o
);

  logic [3:0] outst_q;   // granted requests still waiting for rvalid
  int         fail_cnt = 0;   // failed assertions, read back by the testbench

  always_ff @(posedge clk_i) begin
    if (rst_i) outst_q <= '0;
    else       outst_q <= outst_q + 4'(data_req_o & data_gnt_i) - 4'(data_rvalid_i);
  end

  // request held with stable payload until granted
  a_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o) && $stable(data_we_o)
      && $stable(data_be_o) && $stable(data_wdata_o))
    else begin
      fail_cnt++;
      $error("data request changed before grant");
    end

  a_rvalid_owed: assert property (@(posedge clk_i) disable iff (rst_i)
    data_rvalid_i |-> outst_q != 4'd0)
    else begin
      fail_cnt++;
      $error("rvalid with no outstanding request");
    end

  a_res_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_rdata_o) && $stable(res_err_o))
    else begin
      fail_cnt++;
      $error("result changed while stalled");
    end

endmodule

bind riscv_data_unit riscv_data_unit_asserts asserts_i (.*);

// File: testbench/tb_riscv_data_unit.sv
// data unit testbench with memory model, random ops, reference check and csr tally

`timescale 1ns/1ps

module tb_riscv_data_unit;

  import riscv_pkg::*;

  localparam int DEPTH = LSU_DEPTH_DEFAULT;

  logic clk_i, rst_i;
  logic op_valid_i, op_ready_o, op_we_i, op_sign_ext_i;
  mem_type_e op_type_i;
  xlen_t op_addr_i, op_wdata_i;
  logic res_valid_o, res_ready_i, res_err_o;
  xlen_t res_rdata_o;
  logic data_req_o, data_gnt_i, data_rvalid_i, data_we_o, data_err_i;
  be_t data_be_o;
  xlen_t data_addr_o, data_wdata_o, data_rdata_i;
  logic csr_req_i, csr_we_i, busy_o;
  csr_addr_t csr_addr_i;
  xlen_t csr_wdata_i, csr_rdata_o;

  riscv_data_unit #(.DEPTH(DEPTH)) DUT (.*);

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;   // 8 ns period

  xlen_t mem [256];            // bus side memory written through be and wdata
  xlen_t shadow [256];         // reference copy written from the op itself
  lsu_res_t exp_q [$];         // expected results in acceptance order
  xlen_t r_data [$];           // memory model response pipe
  logic r_err [$];
  int r_due [$];
  logic [31:0] rng_q = 32'hc2c0;
  int cyc, last_due, bus_outst, fails, checks, issued;
  int ld_tally, st_tally, err_tally;
  xlen_t last_err_addr, rd;
  logic stress;                // random grant and res_ready
  logic [7:0] idx;

  function automatic logic [31:0] next_rand();
    rng_q ^= rng_q << 13;
    rng_q ^= rng_q >> 17;
    rng_q ^= rng_q << 5;
    return rng_q;
  endfunction

  function automatic xlen_t fill_word(int i);
    return (i * 32'h0100_0193) ^ {4{8'(i)}};   // every address bit shows up
  endfunction

  function automatic logic is_misaligned(mem_type_e t, xlen_t a);
    return (t == MEM_HALF && a[1:0] == 2'd3) || (t == MEM_WORD && a[1:0] != 2'd0);
  endfunction

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic lsu_res_t ref_result(logic we, mem_type_e t, logic sx, xlen_t a);
    lsu_res_t r;
    xlen_t w;
    r = '0;
    if (is_misaligned(t, a) || a[9:2] >= 8'he0) begin   // upper words answer with bus error
      r.err = 1'b1;
      return r;
    end
    if (we) return r;
    w = shadow[a[9:2]] >> (8 * a[1:0]);
    case (t)
      MEM_BYTE: r.rdata = sx ? {{24{w[7]}}, w[7:0]} : {24'h0, w[7:0]};
      MEM_HALF: r.rdata = sx ? {{16{w[15]}}, w[15:0]} : {16'h0, w[15:0]};
      default:  r.rdata = w;
    endcase
    return r;
  endfunction

  task automatic shadow_store(mem_type_e t, xlen_t a, xlen_t d);
    int n;
    n = (t == MEM_BYTE) ? 1 : (t == MEM_HALF) ? 2 : 4;
    for (int b = 0; b < n; b++) shadow[a[9:2]][8*(a[1:0]+b) +: 8] = d[8*b +: 8];
  endtask

  task automatic check_res(lsu_res_t got, lsu_res_t exp, string msg);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got rdata %h err %b, expected rdata %h err %b",
               $time, msg, got.rdata, got.err, exp.rdata, exp.err);
      fails++;
    end
  endtask

  task automatic check_word(xlen_t got, xlen_t exp, string msg);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
      fails++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // memory model with random grant and rvalid 1 to 3 cycles later
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    int lat;
    cyc++;
    if (rst_i) begin
      data_gnt_i <= 1'b0;
      data_rvalid_i <= 1'b0;
      data_err_i <= 1'b0;
    end else begin
      if (data_req_o && data_gnt_i) begin
        if (bus_outst >= DEPTH) begin
          $display("bus granted a request while %0d were already outstanding", bus_outst);
          fails++;
        end
        idx = data_addr_o[9:2];
        if (data_we_o && idx < 8'he0)
          for (int b = 0; b < 4; b++)
            if (data_be_o[b]) mem[idx][8*b +: 8] = data_wdata_o[8*b +: 8];
        r_data.push_back(idx >= 8'he0 ? 32'h0 : mem[idx]);   // read at grant in order
        r_err.push_back(idx >= 8'he0);
        lat = int'(next_rand() % 3);
        last_due = (cyc + lat > last_due) ? cyc + lat : last_due + 1;
        r_due.push_back(last_due);
        bus_outst++;
      end
      data_rvalid_i <= 1'b0;
      data_err_i <= 1'b0;
      if (r_due.size() != 0 && r_due[0] <= cyc) begin
        data_rvalid_i <= 1'b1;
        data_rdata_i <= r_data.pop_front();
        data_err_i <= r_err.pop_front();
        void'(r_due.pop_front());
        bus_outst--;
      end
      data_gnt_i <= stress ? 1'(next_rand() % 2) : 1'b1;
      res_ready_i <= stress ? (next_rand() % 4 != 0) : 1'b1;
    end
  end

  // compare process pops one expected entry per result handshake
  always @(posedge clk_i) begin
    if (!rst_i && res_valid_o && res_ready_i) begin
      check_word({31'h0, busy_o}, 32'd1, "busy with a result waiting");
      if (exp_q.size() == 0) begin
        $display("a result arrived at %0t with no operation waiting for it", $time);
        fails++;
      end else begin
        check_res(lsu_res_t'({res_rdata_o, res_err_o}), exp_q.pop_front(), "result");
      end
    end
  end

  // watchdog budget grows with the ops issued so far
  initial begin
    int wd_cyc;
    wd_cyc = 0;
    forever begin
      @(posedge clk_i);
      wd_cyc++;
      if (wd_cyc > 200 * (issued + 20)) begin
        $display("the run did not finish within its cycle budget");
        $display("TEST FAILED");
        $finish;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic do_op(logic we, mem_type_e t, logic sx, xlen_t a, xlen_t d);
    lsu_res_t e;
    e = ref_result(we, t, sx, a);
    exp_q.push_back(e);
    if (!is_misaligned(t, a)) begin
      if (we) st_tally++;
      else    ld_tally++;
    end
    if (e.err) begin
      err_tally++;
      last_err_addr = a;
    end else if (we) begin
      shadow_store(t, a, d);
    end
    issued++;
    op_valid_i <= 1'b1;
    op_we_i <= we;
    op_type_i <= t;
    op_sign_ext_i <= sx;
    op_addr_i <= a;
    op_wdata_i <= d;
    do @(posedge clk_i); while (!op_ready_o);   // transfer seen on this edge
  endtask

  task automatic rand_op(logic allow_we, logic allow_bad);
    mem_type_e t;
    xlen_t a;
    t = mem_type_e'(next_rand() % 3);
    a = {22'h0, 8'(next_rand() % 224), 2'(next_rand())};   // outside the error words
    if (!allow_bad) begin
      if (t == MEM_WORD) a[1:0] = 2'd0;
      if (t == MEM_HALF && a[1:0] == 2'd3) a[1:0] = 2'd2;
    end else if (next_rand() % 3 == 0) begin
      a[9:8] = 2'b11;
      a[7:5] = 3'b111;
    end
    do_op(allow_we && next_rand() % 2, t, 1'(next_rand() % 2), a, next_rand());
    if (stress && next_rand() % 4 == 0) begin
      op_valid_i <= 1'b0;   // idle gap
      @(posedge clk_i);
    end
  endtask

  task automatic drain();
    op_valid_i <= 1'b0;
    while (exp_q.size() != 0) @(posedge clk_i);
    repeat (3) @(posedge clk_i);   // let the error event reach the csrs
    check_word({31'h0, busy_o}, '0, "busy after drain");
  endtask

  task automatic csr_read(csr_addr_t a, output xlen_t d);
    csr_req_i <= 1'b1;
    csr_we_i <= 1'b0;
    csr_addr_i <= a;
    @(posedge clk_i);
    d = csr_rdata_o;
    csr_req_i <= 1'b0;
  endtask

  task automatic csr_write(csr_addr_t a, xlen_t d);
    csr_req_i <= 1'b1;
    csr_we_i <= 1'b1;
    csr_addr_i <= a;
    csr_wdata_i <= d;
    @(posedge clk_i);
    csr_req_i <= 1'b0;
    csr_we_i <= 1'b0;
  endtask

  task automatic end_test(string name, int fails_before);
    $display("test %s done, %0d failures", name, fails - fails_before);
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int f0;
    {op_valid_i, op_we_i, op_sign_ext_i, res_ready_i, data_gnt_i} = '0;
    {data_rvalid_i, data_err_i, csr_req_i, csr_we_i, stress} = '0;
    op_type_i = MEM_BYTE;
    {op_addr_i, op_wdata_i, data_rdata_i, csr_wdata_i} = '0;
    csr_addr_i = '0;
    {cyc, last_due, bus_outst, fails, checks, issued} = '0;
    {ld_tally, st_tally, err_tally} = '0;
    last_err_addr = '0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = fill_word(i);
      shadow[i] = fill_word(i);
    end
    rst_i = 1'b1;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);

    f0 = fails;   // outputs idle and csrs clear
    check_word({28'h0, data_req_o, op_ready_o, res_valid_o, busy_o}, '0, "idle outputs");
    csr_read(CSR_LOAD_CNT, rd);
    check_word(rd, '0, "load count after reset");
    csr_read(CSR_STORE_CNT, rd);
    check_word(rd, '0, "store count after reset");
    csr_read(CSR_ERR_CNT, rd);
    check_word(rd, '0, "error count after reset");
    csr_read(CSR_ERR_ADDR, rd);
    check_word(rd, '0, "error address after reset");
    end_test("reset", f0);

    f0 = fails;
    for (int i = 0; i < 60; i++) rand_op(1'b0, 1'b0);
    drain();
    end_test("loads", f0);

    f0 = fails;
    for (int i = 0; i < 80; i++) rand_op(1'b1, 1'b0);
    drain();
    end_test("stores", f0);

    f0 = fails;
    stress = 1'b1;
    for (int i = 0; i < 100; i++) rand_op(1'b1, 1'b0);
    drain();
    end_test("stress", f0);

    f0 = fails;
    for (int i = 0; i < 60; i++) rand_op(1'b1, 1'b1);
    drain();
    stress = 1'b0;
    csr_read(CSR_ERR_CNT, rd);
    check_word(rd, err_tally, "error count");
    csr_read(CSR_ERR_ADDR, rd);
    check_word(rd, last_err_addr, "error address");
    end_test("errors", f0);

    f0 = fails;
    csr_read(CSR_LOAD_CNT, rd);
    check_word(rd, ld_tally, "load count");
    csr_read(CSR_STORE_CNT, rd);
    check_word(rd, st_tally, "store count");
    csr_write(CSR_LOAD_CNT, 32'd100);
    csr_read(CSR_LOAD_CNT, rd);
    check_word(rd, 32'd100, "load count write");
    ld_tally = 100;
    for (int i = 0; i < 10; i++) do_op(1'b0, MEM_WORD, 1'b0, {22'h0, 8'(i), 2'b00}, '0);
    drain();
    csr_read(CSR_LOAD_CNT, rd);
    check_word(rd, ld_tally, "load count resumed");
    end_test("counters", f0);

    if (DUT.asserts_i.fail_cnt != 0) begin
      $display("%0d protocol assertions failed", DUT.asserts_i.fail_cnt);
      fails += DUT.asserts_i.fail_cnt;
    end
    $display("%0d checks, %0d failures, %0d operations", checks, fails, issued);
    if (fails == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: files.f
rtl/riscv_pkg.sv
rtl/riscv_lsu_fifo.sv
rtl/riscv_lsu_req.sv
rtl/riscv_lsu_resp.sv
rtl/riscv_cs_registers.sv
rtl/riscv_data_unit.sv
testbench/riscv_data_unit_asserts.sv
testbench/tb_riscv_data_unit.sv

// File: run.sh
#!/bin/sh
# builds the data unit testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_riscv_data_unit -f files.f -o sim_data_unit

./obj_dir/sim_data_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
  exit 1
fi
